// File: source/dvi_defs.svh
`ifndef DVI_DEFS_SVH
`define DVI_DEFS_SVH

// width of one encoded TMDS character
`define DVI_SYMBOL_W 10

// fast clock edges per pixel, one bit per edge
// must match the symbol width for a plain shift-out
`define DVI_SERIAL_RATIO 10

// blue, green and red data lanes
`define DVI_CHANNELS 3

`endif

// File: source/video_pkg.sv
`default_nettype none

package video_pkg;

   // bits in one color component
   localparam int COLOR_W = 8;

   // component positions inside the packed pixel
   // red sits in the high byte, blue in the low byte
   localparam int RED_LSB = 16;
   localparam int GREEN_LSB = 8;
   localparam int BLUE_LSB = 0;

   // control pair bit positions, C0 and C1
   localparam int CTRL_C0 = 0;
   localparam int CTRL_C1 = 1;

   typedef logic [COLOR_W-1:0] color_t;
   typedef logic [3*COLOR_W-1:0] rgb_t;
   typedef logic [1:0] ctrl_t;

endpackage

`default_nettype wire

// File: source/tmds_pkg.sv
`default_nettype none

`include "dvi_defs.svh"

package tmds_pkg;

   // one encoded character as it goes on the wire
   typedef logic [`DVI_SYMBOL_W-1:0] tmds_symbol_t;

   // control characters sent while de is low
   // names follow the C1C0 pair that selects them
   // these have many transitions so the receiver can find word alignment

   // C1=0 C0=0
   localparam tmds_symbol_t ctrl_symbol_00 = 10'b1101010100;

   // C1=0 C0=1
   localparam tmds_symbol_t ctrl_symbol_01 = 10'b0010101011;

   // C1=1 C0=0
   localparam tmds_symbol_t ctrl_symbol_10 = 10'b0101010100;

   // C1=1 C0=1
   localparam tmds_symbol_t ctrl_symbol_11 = 10'b1010101011;

   // on the blue lane C0 is hsync and C1 is vsync
   // green and red always send ctrl_symbol_00 in plain DVI

endpackage

`default_nettype wire

// File: source/pixel_capture.sv
`default_nettype none

module pixel_capture (
   input  wire logic              clk_pixel,
   input  wire logic              rst_n,
   input  wire video_pkg::rgb_t   rgb,
   input  wire logic              hsync,
   input  wire logic              vsync,
   input  wire logic              de,
   output video_pkg::color_t      blue,
   output video_pkg::color_t      green,
   output video_pkg::color_t      red,
   output logic                   de_q,
   output video_pkg::ctrl_t       ctrl_blue,
   output video_pkg::ctrl_t       ctrl_green,
   output video_pkg::ctrl_t       ctrl_red
);
   import video_pkg::*;

   // one register stage, everything lines up with the same pixel edge
   always_ff @(posedge clk_pixel)
   begin
      if (!rst_n)
      begin
         blue <= '0;
         green <= '0;
         red <= '0;
         de_q <= 1'b0;
         ctrl_blue <= '0;
         ctrl_green <= '0;
         ctrl_red <= '0;
      end
      else
      begin
         // split the pixel into its three lanes
         blue <= rgb[BLUE_LSB +: COLOR_W];
         green <= rgb[GREEN_LSB +: COLOR_W];
         red <= rgb[RED_LSB +: COLOR_W];
         de_q <= de;
         // syncs ride on blue only
         ctrl_blue[CTRL_C0] <= hsync;
         ctrl_blue[CTRL_C1] <= vsync;
         // no CTL bits in DVI, green and red stay at 00
         ctrl_green <= '0;
         ctrl_red <= '0;
      end
   end

   // a nonzero CTL pair on green or red would signal HDMI preambles to a sink
   a_no_ctl_on_green_red: assert property (
      @(posedge clk_pixel) disable iff (!rst_n)
      (ctrl_green == '0) && (ctrl_red == '0)
   );

endmodule

`default_nettype wire

// File: source/tmds_channel.sv
`default_nettype none

module tmds_channel (
   input  wire logic              clk_pixel,
   input  wire logic              rst_n,
   input  wire video_pkg::color_t data,
   input  wire video_pkg::ctrl_t  ctrl,
   input  wire logic              de,
   output tmds_pkg::tmds_symbol_t symbol
);
   import tmds_pkg::*;

   // ones in the incoming byte
   logic [3:0] n1_data;
   logic use_xnor;
   // transition-minimized word where bit 8 tells xor (1) from xnor (0)
   logic [8:0] q_m;
   // ones and zeros in the low eight bits of q_m
   logic [3:0] n1_qm;
   logic [3:0] n0_qm;
   // excess of ones over zeros in q_m[7:0]
   logic signed [4:0] balance;
   // the 2*q_m[8] and 2*~q_m[8] terms of the update
   logic signed [4:0] q8_x2;
   logic signed [4:0] nq8_x2;
   // even-valued running disparity over whole symbols
   logic signed [4:0] disp_q;
   logic signed [4:0] disp_next;
   tmds_symbol_t symbol_next;

   assign n1_data = 4'($countones(data));

   // xnor when the byte is ones-heavy or ties at four with bit 0 clear
   assign use_xnor = (n1_data > 4'd4) || ((n1_data == 4'd4) && !data[0]);

   // stage 1 chains each bit with the previous output bit
   always_comb
   begin
      q_m[0] = data[0];
      for (int i = 1; i < 8; i++)
      begin
         q_m[i] = use_xnor ? ~(q_m[i-1] ^ data[i]) : (q_m[i-1] ^ data[i]);
      end
      q_m[8] = ~use_xnor;
   end

   assign n1_qm = 4'($countones(q_m[7:0]));
   assign n0_qm = 4'd8 - n1_qm;
   assign balance = $signed({1'b0, n1_qm}) - $signed({1'b0, n0_qm});
   assign q8_x2 = $signed({3'b000, q_m[8], 1'b0});
   assign nq8_x2 = $signed({3'b000, ~q_m[8], 1'b0});

   // stage 2 balances the word against the running disparity
   always_comb
   begin
      if (!de)
      begin
         // blanking sends the control character and restarts the disparity
         case (ctrl)
            2'b00: symbol_next = ctrl_symbol_00;
            2'b01: symbol_next = ctrl_symbol_01;
            2'b10: symbol_next = ctrl_symbol_10;
            default: symbol_next = ctrl_symbol_11;
         endcase
         disp_next = 5'sd0;
      end
      else if ((disp_q == 5'sd0) || (balance == 5'sd0))
      begin
         // in the neutral case bit 9 is the complement of bit 8
         // invert the data only for xnor words
         symbol_next = {~q_m[8], q_m[8], q_m[8] ? q_m[7:0] : ~q_m[7:0]};
         disp_next = q_m[8] ? (disp_q + balance) : (disp_q - balance);
      end
      else if (((disp_q > 5'sd0) && (balance > 5'sd0)) ||
               ((disp_q < 5'sd0) && (balance < 5'sd0)))
      begin
         // word would push the line further off balance, so invert it
         symbol_next = {1'b1, q_m[8], ~q_m[7:0]};
         disp_next = disp_q + q8_x2 - balance;
      end
      else
      begin
         // word already pulls toward zero and goes out as it is
         symbol_next = {1'b0, q_m[8], q_m[7:0]};
         disp_next = disp_q - nq8_x2 + balance;
      end
   end

   always_ff @(posedge clk_pixel)
   begin
      if (!rst_n)
      begin
         symbol <= '0;
         disp_q <= 5'sd0;
      end
      else
      begin
         symbol <= symbol_next;
         disp_q <= disp_next;
      end
   end

   // the balancing rules keep the line within one byte of dc neutral
   a_disp_bounded: assert property (
      @(posedge clk_pixel) disable iff (!rst_n)
      (disp_q <= 5'sd8) && (disp_q >= -5'sd8)
   );

   // each data word moves the disparity by an even step
   a_disp_even: assert property (
      @(posedge clk_pixel) disable iff (!rst_n)
      !disp_q[0]
   );

endmodule

`default_nettype wire

// File: source/tmds_serializer.sv
`default_nettype none

`include "dvi_defs.svh"

module tmds_serializer (
   input  wire logic                   clk_pixel_x10,
   input  wire logic                   rst_n,
   input  wire tmds_pkg::tmds_symbol_t symbol_blue,
   input  wire tmds_pkg::tmds_symbol_t symbol_green,
   input  wire tmds_pkg::tmds_symbol_t symbol_red,
   output logic [2:0]                  tmds,
   output logic                        tmds_clock
);
   import tmds_pkg::*;

   localparam int PHASE_W = $clog2(`DVI_SERIAL_RATIO);
   localparam logic [PHASE_W-1:0] PHASE_LAST = PHASE_W'(`DVI_SERIAL_RATIO - 1);
   // idle fast cycles between two loads
   localparam int LOAD_GAP = `DVI_SERIAL_RATIO - 1;
   localparam int HALF = `DVI_SERIAL_RATIO / 2;
   // shifted out lsb first, so the ones come first and the rise marks the boundary
   localparam logic [`DVI_SERIAL_RATIO-1:0] CLOCK_WORD = {{HALF{1'b0}}, {HALF{1'b1}}};

   // fast cycle index inside the current pixel
   logic [PHASE_W-1:0] phase;
   // high in the last fast cycle of a pixel, so loads land on pixel edges
   logic load;
   tmds_symbol_t shift_blue;
   tmds_symbol_t shift_green;
   tmds_symbol_t shift_red;
   logic [`DVI_SERIAL_RATIO-1:0] clock_shift;

   assign load = (phase == PHASE_LAST);

   // reset is released on a pixel edge, which keeps this counter in phase
   always_ff @(posedge clk_pixel_x10)
   begin
      if (!rst_n)
      begin
         phase <= '0;
      end
      else if (load)
      begin
         phase <= '0;
      end
      else
      begin
         phase <= phase + 1'b1;
      end
   end

   // lanes stay low after reset until the first load
   always_ff @(posedge clk_pixel_x10)
   begin
      if (!rst_n)
      begin
         shift_blue <= '0;
         shift_green <= '0;
         shift_red <= '0;
         clock_shift <= '0;
      end
      else if (load)
      begin
         // symbols were registered a full pixel earlier, stable here
         shift_blue <= symbol_blue;
         shift_green <= symbol_green;
         shift_red <= symbol_red;
         clock_shift <= CLOCK_WORD;
      end
      else
      begin
         shift_blue <= shift_blue >> 1;
         shift_green <= shift_green >> 1;
         shift_red <= shift_red >> 1;
         clock_shift <= clock_shift >> 1;
      end
   end

   // lane order blue, green, red
   assign tmds = {shift_red[0], shift_green[0], shift_blue[0]};
   assign tmds_clock = clock_shift[0];

   // one load per pixel, never early, never skipped
   a_load_period: assert property (
      @(posedge clk_pixel_x10) disable iff (!rst_n)
      load |=> (!load) [*LOAD_GAP] ##1 load
   );

endmodule

`default_nettype wire

// File: source/dvi_tx.sv
`default_nettype none

`include "dvi_defs.svh"

module dvi_tx (
   input  wire logic              clk_pixel,
   input  wire logic              clk_pixel_x10,
   input  wire logic              rst_n,
   input  wire video_pkg::rgb_t   rgb,
   input  wire logic              hsync,
   input  wire logic              vsync,
   input  wire logic              de,
   output logic [`DVI_CHANNELS-1:0] tmds,
   output logic                   tmds_clock
);
   import video_pkg::*;
   import tmds_pkg::*;

   // captured pixel, one component per lane
   color_t blue;
   color_t green;
   color_t red;
   logic de_q;
   ctrl_t ctrl_blue;
   ctrl_t ctrl_green;
   ctrl_t ctrl_red;
   // encoded characters, one pixel behind the capture stage
   tmds_symbol_t symbol_blue;
   tmds_symbol_t symbol_green;
   tmds_symbol_t symbol_red;

   pixel_capture u_capture (
      .clk_pixel  (clk_pixel),
      .rst_n      (rst_n),
      .rgb        (rgb),
      .hsync      (hsync),
      .vsync      (vsync),
      .de         (de),
      .blue       (blue),
      .green      (green),
      .red        (red),
      .de_q       (de_q),
      .ctrl_blue  (ctrl_blue),
      .ctrl_green (ctrl_green),
      .ctrl_red   (ctrl_red)
   );

   // lane 0
   tmds_channel u_enc_blue (
      .clk_pixel (clk_pixel),
      .rst_n     (rst_n),
      .data      (blue),
      .ctrl      (ctrl_blue),
      .de        (de_q),
      .symbol    (symbol_blue)
   );

   // lane 1
   tmds_channel u_enc_green (
      .clk_pixel (clk_pixel),
      .rst_n     (rst_n),
      .data      (green),
      .ctrl      (ctrl_green),
      .de        (de_q),
      .symbol    (symbol_green)
   );

   // lane 2
   tmds_channel u_enc_red (
      .clk_pixel (clk_pixel),
      .rst_n     (rst_n),
      .data      (red),
      .ctrl      (ctrl_red),
      .de        (de_q),
      .symbol    (symbol_red)
   );

   tmds_serializer u_serializer (
      .clk_pixel_x10 (clk_pixel_x10),
      .rst_n         (rst_n),
      .symbol_blue   (symbol_blue),
      .symbol_green  (symbol_green),
      .symbol_red    (symbol_red),
      .tmds          (tmds),
      .tmds_clock    (tmds_clock)
   );

endmodule

`default_nettype wire

// File: dv/tb_dvi_tx.sv
`default_nettype none

`include "dvi_defs.svh"

module tb_dvi_tx;
   timeunit 1ns;
   timeprecision 100ps;

   import video_pkg::*;
   import tmds_pkg::*;

   localparam int SYM_W = `DVI_SYMBOL_W;
   localparam int LANES = `DVI_CHANNELS;
   localparam int HALF = `DVI_SERIAL_RATIO / 2;
   // pixels in each stimulus phase
   localparam int BLANK_PIXELS = 16;
   localparam int RANDOM_PIXELS = 400;
   localparam int DIRECTED_RUN = 24;
   localparam int DIRECTED_PIXELS = 5 * (DIRECTED_RUN + 1);
   // 12 rounds of active runs of 1..4 and blank runs of 1..3
   localparam int BURST_PIXELS = 54;
   localparam int TAIL_PIXELS = 4;
   localparam int NUM_PIXELS = BLANK_PIXELS + RANDOM_PIXELS + DIRECTED_PIXELS
                               + BURST_PIXELS + TAIL_PIXELS;
   localparam int TIMEOUT_NS = (5 + NUM_PIXELS + 20) * 10;
   localparam logic [7:0] DIRECTED_BYTES [5] = '{8'h00, 8'hFF, 8'h55, 8'hAA, 8'h10};

   logic clk_pixel;
   logic clk_pixel_x10;
   logic rst_n;
   rgb_t rgb;
   logic hsync;
   logic vsync;
   logic de;
   logic [LANES-1:0] tmds;
   logic tmds_clock;

   // expected words as {de, red, green, blue}
   logic [LANES*SYM_W:0] exp_q[$];
   // words rebuilt from the serial lanes as {red, green, blue}
   logic [LANES*SYM_W-1:0] obs_q[$];
   // model running disparity, one per lane
   int disp_model[LANES];
   int errors;
   int checked;
   event word_ready;

   dvi_tx uut (
      .clk_pixel     (clk_pixel),
      .clk_pixel_x10 (clk_pixel_x10),
      .rst_n         (rst_n),
      .rgb           (rgb),
      .hsync         (hsync),
      .vsync         (vsync),
      .de            (de),
      .tmds          (tmds),
      .tmds_clock    (tmds_clock)
   );

   // pixel clock rises first at 5 ns and then every 10 ns
   initial
   begin
      clk_pixel = 1'b0;
      forever #5 clk_pixel = ~clk_pixel;
   end

   // fast clock rises on whole nanoseconds, so every tenth rise meets a pixel rise
   initial
   begin
      clk_pixel_x10 = 1'b1;
      forever #0.5 clk_pixel_x10 = ~clk_pixel_x10;
   end

   function automatic int count_ones(input logic [SYM_W-1:0] w);
      int n;
      n = 0;
      for (int i = 0; i < SYM_W; i++)
      begin
         if (w[i])
         begin
            n++;
         end
      end
      return n;
   endfunction

   // DVI 1.0 encoding of one component with the disparity carried in and out
   function automatic tmds_symbol_t tmds_ref(input color_t d, input ctrl_t c, input logic en,
                                             input int disp_in, output int disp_out);
      logic [8:0] qm;
      logic xnor_sel;
      int n1;
      int diff;
      tmds_symbol_t sym;
      if (!en)
      begin
         case (c)
            2'b00: sym = ctrl_symbol_00;
            2'b01: sym = ctrl_symbol_01;
            2'b10: sym = ctrl_symbol_10;
            default: sym = ctrl_symbol_11;
         endcase
         // blanking restarts the balance
         disp_out = 0;
      end
      else
      begin
         n1 = count_ones({2'b00, d});
         xnor_sel = (n1 > 4) || ((n1 == 4) && !d[0]);
         qm[0] = d[0];
         for (int i = 1; i < 8; i++)
         begin
            qm[i] = xnor_sel ? ~(qm[i-1] ^ d[i]) : (qm[i-1] ^ d[i]);
         end
         qm[8] = !xnor_sel;
         // ones minus zeros of the low byte
         diff = 2 * count_ones({2'b00, qm[7:0]}) - 8;
         if ((disp_in == 0) || (diff == 0))
         begin
            sym = {~qm[8], qm[8], qm[8] ? qm[7:0] : ~qm[7:0]};
            disp_out = qm[8] ? disp_in + diff : disp_in - diff;
         end
         else if (((disp_in > 0) && (diff > 0)) || ((disp_in < 0) && (diff < 0)))
         begin
            sym = {1'b1, qm[8], ~qm[7:0]};
            disp_out = disp_in + 2 * int'(qm[8]) - diff;
         end
         else
         begin
            sym = {1'b0, qm[8], qm[7:0]};
            disp_out = disp_in - 2 * int'(!qm[8]) + diff;
         end
      end
      return sym;
   endfunction

   task automatic queue_expected(input rgb_t pix, input logic hs, input logic vs,
                                 input logic en);
      tmds_symbol_t sym_b;
      tmds_symbol_t sym_g;
      tmds_symbol_t sym_r;
      // syncs only on blue with C0 as hsync and C1 as vsync
      sym_b = tmds_ref(pix[7:0], {vs, hs}, en, disp_model[0], disp_model[0]);
      sym_g = tmds_ref(pix[15:8], 2'b00, en, disp_model[1], disp_model[1]);
      sym_r = tmds_ref(pix[23:16], 2'b00, en, disp_model[2], disp_model[2]);
      exp_q.push_back({en, sym_r, sym_g, sym_b});
   endtask

   // the DUT samples these values on the pixel edge after the call
   task automatic apply_pixel(input rgb_t pix, input logic hs, input logic vs, input logic en);
      rgb <= pix;
      hsync <= hs;
      vsync <= vs;
      de <= en;
      queue_expected(pix, hs, vs, en);
      @(posedge clk_pixel);
   endtask

   initial
   begin : stimulus
      void'($urandom(32'h5b7d_00e3));
      errors = 0;
      checked = 0;
      rst_n <= 1'b0;
      rgb <= '0;
      hsync <= 1'b0;
      vsync <= 1'b0;
      de <= 1'b0;
      // first load after reset picks up the cleared encoder registers
      exp_q.push_back('0);
      // next one encodes the cleared capture stage as blanking with C1C0 = 00
      exp_q.push_back({1'b0, ctrl_symbol_00, ctrl_symbol_00, ctrl_symbol_00});
      repeat (5) @(posedge clk_pixel);
      rst_n <= 1'b1;
      // every hsync and vsync combination during blanking
      for (int s = 0; s < 4; s++)
      begin
         repeat (4) apply_pixel(rgb_t'($urandom), s[0], s[1], 1'b0);
      end
      repeat (RANDOM_PIXELS) apply_pixel(rgb_t'($urandom), 1'b0, 1'b0, 1'b1);
      // long runs of one byte hit xor, xnor, inversion and the zero cases
      for (int b = 0; b < 5; b++)
      begin
         apply_pixel(rgb_t'($urandom), 1'b0, 1'b0, 1'b0);
         repeat (DIRECTED_RUN)
         begin
            apply_pixel({DIRECTED_BYTES[b], ~DIRECTED_BYTES[b], DIRECTED_BYTES[b]},
                        1'b0, 1'b0, 1'b1);
         end
      end
      // disparity must restart after each blank run of the short bursts
      for (int r = 0; r < 12; r++)
      begin
         repeat ((r % 4) + 1) apply_pixel(rgb_t'($urandom), 1'b0, 1'b0, 1'b1);
         repeat ((r % 3) + 1) apply_pixel(rgb_t'($urandom), 1'($urandom), 1'($urandom), 1'b0);
      end
      repeat (TAIL_PIXELS) apply_pixel('0, 1'b0, 1'b0, 1'b0);
      while (exp_q.size() > 0)
      begin
         @(posedge clk_pixel);
      end
      $display("%0d errors, %0d words checked", errors, checked);
      if (errors == 0)
      begin
         $display("Finished with no errors");
      end
      else
      begin
         $display("Finished with errors");
      end
      $finish;
   end

   // samples mid bit and rebuilds one word per tmds_clock period
   initial
   begin : monitor
      logic started;
      int bit_idx;
      logic [LANES*SYM_W-1:0] word;
      started = 1'b0;
      bit_idx = 0;
      word = '0;
      forever
      begin
         @(negedge clk_pixel_x10);
         if (!started && (tmds_clock === 1'b1))
         begin
            started = 1'b1;
         end
         if (!started)
         begin
            if ((rst_n === 1'b1) && ((tmds !== '0) || (tmds_clock !== 1'b0)))
            begin
               errors++;
               $display("FAILED at %0t: lanes or clock not low before the first word", $time);
            end
         end
         else
         begin
            // clock lane is five ones then five zeros
            if (tmds_clock !== (bit_idx < HALF))
            begin
               errors++;
               $display("FAILED at %0t: tmds_clock bit %0d is %b", $time, bit_idx, tmds_clock);
            end
            for (int lane = 0; lane < LANES; lane++)
            begin
               word[lane*SYM_W + bit_idx] = tmds[lane];
            end
            bit_idx++;
            if (bit_idx == `DVI_SERIAL_RATIO)
            begin
               obs_q.push_back(word);
               bit_idx = 0;
               -> word_ready;
            end
         end
      end
   end

   initial
   begin : compare
      logic [LANES*SYM_W-1:0] obs;
      logic [LANES*SYM_W:0] expw;
      tmds_symbol_t exp_sym;
      tmds_symbol_t obs_sym;
      // ones minus zeros seen on each lane since the last blanking
      int balance[LANES];
      for (int lane = 0; lane < LANES; lane++)
      begin
         balance[lane] = 0;
      end
      forever
      begin
         @(word_ready);
         while (obs_q.size() > 0)
         begin
            obs = obs_q.pop_front();
            // words after the last expected one are idle blanking
            if (exp_q.size() > 0)
            begin
               expw = exp_q.pop_front();
               checked++;
               for (int lane = 0; lane < LANES; lane++)
               begin
                  exp_sym = expw[lane*SYM_W +: SYM_W];
                  obs_sym = obs[lane*SYM_W +: SYM_W];
                  if (obs_sym !== exp_sym)
                  begin
                     errors++;
                     $display("FAILED at %0t: lane %0d expected %b observed %b",
                              $time, lane, exp_sym, obs_sym);
                  end
                  if (!expw[LANES*SYM_W])
                  begin
                     balance[lane] = 0;
                  end
                  else
                  begin
                     balance[lane] += 2 * count_ones(obs_sym) - SYM_W;
                     if ((balance[lane] > 8) || (balance[lane] < -8))
                     begin
                        errors++;
                        $display("FAILED at %0t: lane %0d dc balance at %0d",
                                 $time, lane, balance[lane]);
                     end
                  end
               end
            end
         end
      end
   end

   initial
   begin : watchdog
      #(TIMEOUT_NS);
      $display("timeout after %0d ns, the expected words did not all arrive", TIMEOUT_NS);
      $display("Finished with errors");
      $finish;
   end

endmodule

`default_nettype wire

// File: dvi_tx.f
+incdir+source
source/video_pkg.sv
source/tmds_pkg.sv
source/pixel_capture.sv
source/tmds_channel.sv
source/tmds_serializer.sv
source/dvi_tx.sv
dv/tb_dvi_tx.sv

// File: Makefile
TOP := tb_dvi_tx

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --timescale 1ns/100ps \
		-f dvi_tx.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		-f dvi_tx.f --top-module $(TOP)
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qx "Finished with no errors"

clean:
	rm -rf obj_dir
